/* branch_params.svh */
`ifndef BRANCH_PARAMS_SVH
`define BRANCH_PARAMS_SVH

// Datapath word, used for addresses and operands
`define WORD_W 32

// Jump index field in J-type instructions
`define JIMM_W 26

// Jump index after the shift by two
`define REGION_W 28

// Redirect address for illegal or unknown instructions
`define TRAP_ADDR 0

`endif

/* branch_pkg.sv */
`include "branch_params.svh"

package branch_pkg;

    typedef logic [`WORD_W-1:0] wordT;

    // Selection codes seen by the PC source block
    typedef enum logic [3:0] {
        selGez     = 4'b0000,
        selEq      = 4'b0001,
        selNe      = 4'b0010,
        selGtz     = 4'b0011,
        selLez     = 4'b0100,
        selLtz     = 4'b0101,
        selJump    = 4'b0110,
        selJr      = 4'b0111,
        selAlways  = 4'b1000,
        selIllegal = 4'b1111
    } branchSelT;

    // Stage 1 payload, everything the resolve logic needs
    typedef struct packed {
        branchSelT            sel;
        wordT                 aluResult;
        logic                 zero;
        wordT                 addResult;
        logic [`REGION_W-1:0] imm;
    } decodeT;

    // Stage 2 payload, the redirect decision
    typedef struct packed {
        logic pcSrc;
        wordT pcNew;
    } resolveT;

endpackage

/* stageReg.sv */
`timescale 1ns/1ps

module stageReg #(
    parameter type payloadT = logic
) (
    input  logic    clk,
    input  logic    arstN,
    input  logic    inValid,
    input  payloadT inData,
    output logic    outValid,
    output payloadT outData
);

    // Valid bit follows the input every cycle
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            outValid <= 1'b0;
        end else begin
            outValid <= inValid;
        end
    end

    // Payload only moves with a valid item, otherwise holds
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            outData <= '0;
        end else if (inValid) begin
            outData <= inData;
        end
    end

endmodule

/* branchDecoder.sv */
`timescale 1ns/1ps

module branchDecoder
    import branch_pkg::*;
(
    input  wordT      instr,
    output branchSelT branchSel,
    output logic      useRt
);

    ////////////////////////////////////////////////////////////
    // MIPS encodings
    ////////////////////////////////////////////////////////////

    localparam logic [5:0] OP_SPECIAL = 6'b000000;
    localparam logic [5:0] OP_REGIMM  = 6'b000001;
    localparam logic [5:0] OP_J       = 6'b000010;
    localparam logic [5:0] OP_JAL     = 6'b000011;
    localparam logic [5:0] OP_BEQ     = 6'b000100;
    localparam logic [5:0] OP_BNE     = 6'b000101;
    localparam logic [5:0] OP_BLEZ    = 6'b000110;
    localparam logic [5:0] OP_BGTZ    = 6'b000111;

    // REGIMM sub-codes live in the rt field
    localparam logic [4:0] RT_BLTZ    = 5'b00000;
    localparam logic [4:0] RT_BGEZ    = 5'b00001;
    localparam logic [4:0] RT_BGEZAL  = 5'b10001;

    localparam logic [5:0] FN_JR      = 6'b001000;

    logic [5:0] opcode;
    logic [4:0] rtField;
    logic [5:0] funct;

    assign opcode  = instr[31:26];
    assign rtField = instr[20:16];
    assign funct   = instr[5:0];

    ////////////////////////////////////////////////////////////
    // Selection decode
    ////////////////////////////////////////////////////////////

    always_comb begin
        branchSel = selIllegal;
        case (opcode)
            OP_BEQ:  branchSel = selEq;
            OP_BNE:  branchSel = selNe;
            OP_BLEZ: branchSel = selLez;
            OP_BGTZ: branchSel = selGtz;
            OP_J,
            OP_JAL:  branchSel = selJump;
            OP_REGIMM: begin
                case (rtField)
                    RT_BGEZ:   branchSel = selGez;
                    RT_BLTZ:   branchSel = selLtz;
                    RT_BGEZAL: branchSel = selAlways;
                    default:   branchSel = selIllegal;
                endcase
            end
            OP_SPECIAL: begin
                if (funct == FN_JR) begin
                    branchSel = selJr;
                end
            end
            default: branchSel = selIllegal;
        endcase
    end

    // Only the two-register compares need rt, the rest test rs against zero
    assign useRt = (opcode == OP_BEQ) || (opcode == OP_BNE);

endmodule

/* operandCompare.sv */
`timescale 1ns/1ps

module operandCompare
    import branch_pkg::*;
(
    input  wordT rsData,
    input  wordT rtData,
    input  logic useRt,
    output wordT aluResult,
    output logic zero
);

    wordT subtrahend;

    // Zero stands in for rt on compares against zero
    assign subtrahend = useRt ? rtData : '0;

    // Wraps modulo 2^32, read as signed downstream
    assign aluResult = rsData - subtrahend;

    assign zero = (aluResult == '0);

endmodule

/* targetGen.sv */
`timescale 1ns/1ps
`include "branch_params.svh"

module targetGen
    import branch_pkg::*;
(
    input  wordT                 pc,
    input  wordT                 instr,
    output wordT                 addResult,
    output logic [`REGION_W-1:0] imm
);

    localparam int OFFSET_W = 16;
    localparam int EXT_W    = $bits(wordT) - OFFSET_W - 2;

    wordT seqPc;
    wordT offset;

    ////////////////////////////////////////////////////////////
    // Branch target
    ////////////////////////////////////////////////////////////

    // Address of the following instruction
    assign seqPc = pc + wordT'(4);

    // Sign-extended word offset, in bytes
    assign offset = {{EXT_W{instr[OFFSET_W-1]}}, instr[OFFSET_W-1:0], 2'b00};

    assign addResult = seqPc + offset;

    ////////////////////////////////////////////////////////////
    // Jump region field
    ////////////////////////////////////////////////////////////

    // Upper PC bits are spliced on in the resolve stage
    assign imm = {instr[`JIMM_W-1:0], 2'b00};

endmodule

/* pcSrcControl.sv */
`timescale 1ns/1ps
`include "branch_params.svh"

module pcSrcControl
    import branch_pkg::*;
(
    input  branchSelT            branchSel,
    input  logic                 zero,
    input  wordT                 aluResult,
    input  wordT                 addResult,
    input  logic [`REGION_W-1:0] imm,
    output logic                 pcSrc,
    output wordT                 pcNew
);

    // PC bits kept above the jump region
    localparam int HI_W = $bits(wordT) - `REGION_W;

    logic signed [$bits(wordT)-1:0] diff;
    logic                           taken;
    wordT                           target;
    wordT                           jumpTarget;

    assign diff       = aluResult;
    assign jumpTarget = {addResult[$bits(wordT)-1 -: HI_W], imm};

    ////////////////////////////////////////////////////////////
    // Redirect decision
    ////////////////////////////////////////////////////////////

    always_comb begin
        taken  = 1'b0;
        target = addResult;
        case (branchSel)
            // Conditional branches on rs - rt (or rs - 0)
            selGez: taken = (diff >= 0);
            selEq:  taken = zero;
            selNe:  taken = !zero;
            selGtz: taken = (diff > 0);
            selLez: taken = (diff <= 0);
            selLtz: taken = (diff < 0);

            // Unconditional transfers
            selJump: begin
                taken  = 1'b1;
                target = jumpTarget;
            end
            selJr: begin
                taken  = 1'b1;
                target = aluResult;
            end
            selAlways: begin
                taken  = 1'b1;
                target = addResult;
            end

            // Illegal code, go to the trap vector
            default: begin
                taken  = 1'b1;
                target = wordT'(`TRAP_ADDR);
            end
        endcase
    end

    // Not taken reports a zero address
    assign pcSrc = taken;
    assign pcNew = taken ? target : '0;

endmodule

/* branchUnitTop.sv */
`timescale 1ns/1ps
`include "branch_params.svh"

module branchUnitTop
    import branch_pkg::*;
(
    input  logic clk,
    input  logic arstN,
    input  logic issue,
    input  wordT instr,
    input  wordT pc,
    input  wordT rsData,
    input  wordT rtData,
    output logic resultValid,
    output logic pcSrc,
    output wordT pcNew
);

    branchSelT            branchSel;
    logic                 useRt;
    wordT                 aluResult;
    logic                 zero;
    wordT                 addResult;
    logic [`REGION_W-1:0] imm;

    decodeT  decodeIn;
    decodeT  decodeOut;
    logic    decodeValid;

    resolveT resolveIn;
    resolveT resolveOut;

    ////////////////////////////////////////////////////////////
    // Stage 1 decode, compare and target
    ////////////////////////////////////////////////////////////

    branchDecoder uDecoder (
        .instr     (instr),
        .branchSel (branchSel),
        .useRt     (useRt)
    );

    operandCompare uCompare (
        .rsData    (rsData),
        .rtData    (rtData),
        .useRt     (useRt),
        .aluResult (aluResult),
        .zero      (zero)
    );

    targetGen uTarget (
        .pc        (pc),
        .instr     (instr),
        .addResult (addResult),
        .imm       (imm)
    );

    assign decodeIn.sel       = branchSel;
    assign decodeIn.aluResult = aluResult;
    assign decodeIn.zero      = zero;
    assign decodeIn.addResult = addResult;
    assign decodeIn.imm       = imm;

    stageReg #(.payloadT(decodeT)) decodeStage (
        .clk      (clk),
        .arstN    (arstN),
        .inValid  (issue),
        .inData   (decodeIn),
        .outValid (decodeValid),
        .outData  (decodeOut)
    );

    ////////////////////////////////////////////////////////////
    // Stage 2 resolve
    ////////////////////////////////////////////////////////////

    pcSrcControl uPcSrc (
        .branchSel (decodeOut.sel),
        .zero      (decodeOut.zero),
        .aluResult (decodeOut.aluResult),
        .addResult (decodeOut.addResult),
        .imm       (decodeOut.imm),
        .pcSrc     (resolveIn.pcSrc),
        .pcNew     (resolveIn.pcNew)
    );

    stageReg #(.payloadT(resolveT)) resolveStage (
        .clk      (clk),
        .arstN    (arstN),
        .inValid  (decodeValid),
        .inData   (resolveIn),
        .outValid (resultValid),
        .outData  (resolveOut)
    );

    assign pcSrc = resolveOut.pcSrc;
    assign pcNew = resolveOut.pcNew;

endmodule

/* branchUnit_properties.sv */
`timescale 1ns/1ps

module branchUnit_properties
    import branch_pkg::*;
(
    input logic   clk,
    input logic   arstN,
    input logic   issue,
    input logic   resultValid,
    input logic   pcSrc,
    input logic   stage1Valid,
    input decodeT stage1
);

    int   assertFailures = 0;
    logic uncond;

    // Jumps, branch-always and the trap redirect regardless of operands
    assign uncond = stage1Valid && (stage1.sel inside {selJump, selJr, selAlways, selIllegal});

    resetQuiet: assert property (@(posedge clk) !arstN |-> !resultValid)
        else begin
            assertFailures++;
            $error("resultValid high while reset is active");
        end

    // Fixed two-cycle latency from issue to result
    issueLatency: assert property (@(posedge clk) disable iff (!arstN)
                                   resultValid == $past(issue, 2))
        else begin
            assertFailures++;
            $error("resultValid does not follow issue by two cycles");
        end

    uncondTaken: assert property (@(posedge clk) disable iff (!arstN) uncond |=> pcSrc)
        else begin
            assertFailures++;
            $error("pcSrc low after an unconditional selection");
        end

endmodule

bind branchUnitTop branchUnit_properties props (
    .clk         (clk),
    .arstN       (arstN),
    .issue       (issue),
    .resultValid (resultValid),
    .pcSrc       (pcSrc),
    .stage1Valid (decodeValid),
    .stage1      (decodeOut)
);

/* tb_branchUnit.sv */
`timescale 1ns/1ps
`include "branch_params.svh"

module tb_branchUnit
    import branch_pkg::*;
();

    localparam int          CLK_PERIOD   = 20;
    localparam int          DRIVE_DELAY  = 2;
    localparam int          RESET_CYCLES = 3;
    localparam logic [31:0] SEED         = 32'h926a45f8;

    // Items per test
    localparam int N_COND    = 120;
    localparam int N_JUMP    = 48;
    localparam int N_ILLEGAL = 48;
    localparam int N_STREAM  = 200;
    localparam int N_RANDOM  = 200;
    localparam int SHORT_GAP = 1;
    localparam int MAX_GAP   = 3;

    // Worst case run length, with gaps and the drain after each test
    localparam int RUN_CYCLES = RESET_CYCLES + 8
                              + (N_COND + N_JUMP + N_ILLEGAL) * (SHORT_GAP + 1)
                              + N_STREAM + N_RANDOM * (MAX_GAP + 1) + 6 * 6 + 20;

    logic  clk;
    logic  arstN;
    logic  issue;
    wordT  instr;
    wordT  pc;
    wordT  rsData;
    wordT  rtData;
    logic  resultValid;
    logic  pcSrc;
    wordT  pcNew;

    // Expected results, oldest first
    logic  expSrcQ[$];
    wordT  expNewQ[$];
    int    dueQ[$];

    string testName;
    int    cycleCount = 0;
    int    passCount = 0;
    int    failCount = 0;
    int    failsAtStart = 0;
    int    issuedInTest = 0;
    int    resultsInTest = 0;

    branchUnitTop dut (
        .clk         (clk),
        .arstN       (arstN),
        .issue       (issue),
        .instr       (instr),
        .pc          (pc),
        .rsData      (rsData),
        .rtData      (rtData),
        .resultValid (resultValid),
        .pcSrc       (pcSrc),
        .pcNew       (pcNew)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) cycleCount <= cycleCount + 1;

    //////////////////////////////////////////////////////////////
    // Compare tasks
    //////////////////////////////////////////////////////////////

    task automatic checkWord(input string name, input wordT expected, input wordT actual);
        if (expected !== actual) begin
            $display("mismatch %s: expected %h, actual %h", name, expected, actual);
            failCount++;
        end else begin
            passCount++;
        end
    endtask

    task automatic checkBit(input string name, input logic expected, input logic actual);
        if (expected !== actual) begin
            $display("mismatch %s: expected %b, actual %b", name, expected, actual);
            failCount++;
        end else begin
            passCount++;
        end
    endtask

    //////////////////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////////////////

    function automatic void modelResolve(input wordT iw, input wordT pcW, input wordT rs,
                                         input wordT rt, output logic expSrc,
                                         output wordT expNew);
        logic [5:0] op;
        int signed  d;
        int signed  offs;
        wordT       brTarget;
        logic       isCond;
        logic       cond;
        op       = iw[31:26];
        offs     = int'(signed'(iw[15:0])) * 4;
        brTarget = pcW + 32'd4 + wordT'(offs);
        // Only beq and bne compare two registers
        d        = (op == 6'd4 || op == 6'd5) ? int'(rs - rt) : int'(rs);
        isCond   = 1'b0;
        cond     = 1'b0;
        expSrc   = 1'b1;
        expNew   = wordT'(`TRAP_ADDR);
        case (op)
            6'd4: begin
                isCond = 1'b1;
                cond   = (d == 0);
            end
            6'd5: begin
                isCond = 1'b1;
                cond   = (d != 0);
            end
            6'd6: begin
                isCond = 1'b1;
                cond   = (d <= 0);
            end
            6'd7: begin
                isCond = 1'b1;
                cond   = (d > 0);
            end
            6'd1: begin
                if (iw[20:16] == 5'd1) begin
                    isCond = 1'b1;
                    cond   = (d >= 0);
                end else if (iw[20:16] == 5'd0) begin
                    isCond = 1'b1;
                    cond   = (d < 0);
                end else if (iw[20:16] == 5'd17) begin
                    expNew = brTarget;
                end
            end
            6'd2, 6'd3: expNew = {brTarget[31:28], iw[`JIMM_W-1:0], 2'b00};
            6'd0: begin
                if (iw[5:0] == 6'd8) expNew = rs;
            end
            default: ;
        endcase
        if (isCond) begin
            expSrc = cond;
            expNew = cond ? brTarget : '0;
        end
    endfunction

    //////////////////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////////////////

    // Kinds 0..5 conditional, 6 always, 7 j/jal, 8 jr, 9 illegal
    function automatic wordT makeInstr(input int kind);
        wordT       w;
        logic [4:0] rtf;
        w = $urandom();
        case (kind)
            0: w[31:26] = 6'd4;
            1: w[31:26] = 6'd5;
            2: w[31:26] = 6'd7;
            3: w[31:26] = 6'd6;
            4: begin
                w[31:26] = 6'd1;
                w[20:16] = 5'd1;
            end
            5: begin
                w[31:26] = 6'd1;
                w[20:16] = 5'd0;
            end
            6: begin
                w[31:26] = 6'd1;
                w[20:16] = 5'd17;
            end
            7: w[31:27] = 5'b00001;
            8: begin
                w[31:26] = 6'd0;
                w[5:0]   = 6'd8;
            end
            default: begin
                case ($urandom_range(0, 2))
                    0: w[31:26] = 6'($urandom_range(8, 63));
                    1: begin
                        w[31:26] = 6'd0;
                        if (w[5:0] == 6'd8) w[5:0] = 6'd9;
                    end
                    default: begin
                        rtf = 5'($urandom_range(2, 31));
                        if (rtf == 5'd17) rtf = 5'd18;
                        w[31:26] = 6'd1;
                        w[20:16] = rtf;
                    end
                endcase
            end
        endcase
        return w;
    endfunction

    function automatic int pickKind();
        int r;
        r = $urandom_range(0, 99);
        if (r < 54) return r / 9;
        else if (r < 66) return 6;
        else if (r < 76) return 7;
        else if (r < 86) return 8;
        return 9;
    endfunction

    // Equal pairs and edge values for rs
    task automatic pickOperands(output wordT rs, output wordT rt);
        int r;
        rs = $urandom();
        rt = $urandom();
        r  = $urandom_range(0, 99);
        if (r < 25) rt = rs;
        else if (r < 35) rs = '0;
        else if (r < 45) rs = 32'h8000_0000;
    endtask

    task automatic sendItem(input int kind);
        wordT iw;
        wordT pcW;
        wordT rs;
        wordT rt;
        logic expSrc;
        wordT expNew;
        iw  = makeInstr(kind);
        pcW = $urandom();
        pcW[1:0] = 2'b00;
        pickOperands(rs, rt);
        modelResolve(iw, pcW, rs, rt, expSrc, expNew);
        instr  = iw;
        pc     = pcW;
        rsData = rs;
        rtData = rt;
        issue  = 1'b1;
        expSrcQ.push_back(expSrc);
        expNewQ.push_back(expNew);
        dueQ.push_back(cycleCount + 2);
        issuedInTest++;
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    task automatic idleCycle();
        issue = 1'b0;
        instr = $urandom();
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    // Mode 0 conditional, 1 jumps, 2 illegal, other values mixed
    task automatic runItems(input int mode, input int count, input int maxGap);
        int kind;
        int gap;
        for (int i = 0; i < count; i++) begin
            gap = (maxGap > 0) ? $urandom_range(0, maxGap) : 0;
            repeat (gap) idleCycle();
            case (mode)
                0: kind = $urandom_range(0, 5);
                1: kind = $urandom_range(6, 8);
                2: kind = 9;
                default: kind = pickKind();
            endcase
            sendItem(kind);
        end
        issue = 1'b0;
    endtask

    //////////////////////////////////////////////////////////////
    // Result monitor
    //////////////////////////////////////////////////////////////

    task automatic checkOutputs();
        if (resultValid) begin
            resultsInTest++;
            if (dueQ.size() == 0) begin
                $display("%s: resultValid high with no item outstanding", testName);
                failCount++;
            end else begin
                if (dueQ[0] != cycleCount) begin
                    $display("%s: result came at cycle %0d instead of cycle %0d",
                             testName, cycleCount, dueQ[0]);
                    failCount++;
                end
                checkBit({testName, " pcSrc"}, expSrcQ[0], pcSrc);
                checkWord({testName, " pcNew"}, expNewQ[0], pcNew);
                void'(expSrcQ.pop_front());
                void'(expNewQ.pop_front());
                void'(dueQ.pop_front());
            end
        end else if (dueQ.size() != 0 && dueQ[0] <= cycleCount) begin
            $display("%s: no result at cycle %0d for an issued item", testName, cycleCount);
            failCount++;
            void'(expSrcQ.pop_front());
            void'(expNewQ.pop_front());
            void'(dueQ.pop_front());
        end
    endtask

    always @(negedge clk) begin
        if (arstN) checkOutputs();
    end

    task automatic startTest(input string name);
        testName      = name;
        failsAtStart  = failCount;
        issuedInTest  = 0;
        resultsInTest = 0;
    endtask

    task automatic finishTest(input int num);
        int errs;
        issue = 1'b0;
        while (dueQ.size() != 0) @(posedge clk);
        repeat (2) @(posedge clk);
        #DRIVE_DELAY;
        if (resultsInTest != issuedInTest) begin
            $display("%s: %0d results seen for %0d issued items",
                     testName, resultsInTest, issuedInTest);
            failCount++;
        end
        errs = failCount - failsAtStart;
        $display("Test %0d %s: %s, %0d items, %0d errors", num, testName,
                 (errs == 0) ? "ok" : "FAILED", issuedInTest, errs);
    endtask

    // Watchdog
    initial begin
        #(RUN_CYCLES * CLK_PERIOD);
        $display("Timeout: run still active after %0d cycles", RUN_CYCLES);
        $display("Verification failed");
        $finish;
    end

    initial begin
        void'($urandom(SEED));
        arstN  = 1'b0;
        issue  = 1'b0;
        instr  = '0;
        pc     = '0;
        rsData = '0;
        rtData = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        arstN = 1'b1;

        startTest("reset");
        repeat (4) begin
            @(negedge clk);
            checkBit("reset resultValid", 1'b0, resultValid);
            checkBit("reset pcSrc", 1'b0, pcSrc);
            checkWord("reset pcNew", '0, pcNew);
        end
        @(posedge clk);
        #DRIVE_DELAY;
        finishTest(1);

        startTest("conditional branches");
        runItems(0, N_COND, SHORT_GAP);
        finishTest(2);

        startTest("jumps");
        runItems(1, N_JUMP, SHORT_GAP);
        finishTest(3);

        startTest("illegal instructions");
        runItems(2, N_ILLEGAL, SHORT_GAP);
        finishTest(4);

        startTest("back-to-back stream");
        runItems(3, N_STREAM, 0);
        finishTest(5);

        startTest("random traffic");
        runItems(3, N_RANDOM, MAX_GAP);
        finishTest(6);

        $display("Checks passed: %0d, failed: %0d, assertion failures: %0d",
                 passCount, failCount, dut.props.assertFailures);
        if (failCount == 0 && dut.props.assertFailures == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

/* compile.f */
+incdir+.
branch_pkg.sv
stageReg.sv
branchDecoder.sv
operandCompare.sv
targetGen.sv
pcSrcControl.sv
branchUnitTop.sv
branchUnit_properties.sv
tb_branchUnit.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps
TOP       = tb_branchUnit
FILELIST  = compile.f
OBJDIR    = obj_dir
SIM       = $(OBJDIR)/V$(TOP)
LOG       = sim.log
FAIL_MSG  = Verification failed
RUNARGS   = +verilator+error+limit+100

SOURCES   = $(filter-out +%,$(shell cat $(FILELIST)))
HEADERS   = $(wildcard *.svh)

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: $(SIM)
	@./$(SIM) $(RUNARGS) > $(LOG) 2>&1; status=$$?; \
	cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJDIR) $(LOG)
